//--- design/link_consts.svh
`ifndef LINK_CONSTS_SVH
`define LINK_CONSTS_SVH

// Mesh packet geometry
`define PKT_W           104
`define PKT_BYTES       13          // Lane bytes per packet

// Field offsets, counted from bit 0
`define PKT_CTRL_LSB    0           // 8-bit control
`define PKT_DST_LSB     8           // 32-bit destination address
`define PKT_DATA_LSB    40          // 32-bit data
`define PKT_SRC_LSB     72          // 32-bit source address

// Control byte flags
`define CTRL_WRITE_BIT  1           // Set on writes
`define CTRL_RESP_BIT   2           // Set on read responses

// Memory model
`define EMEM_AW         8           // Word address bits, 256 words

`endif

//--- design/emesh_pkg.sv
`default_nettype none
`include "link_consts.svh"

package emesh_pkg;

   typedef logic [`PKT_W-1:0] packet_t;     // Whole mesh packet
   typedef logic [7:0]        ctrl_t;       // Control byte
   typedef logic [31:0]       addr_t;       // Byte address
   typedef logic [31:0]       data_t;       // Data word

   function automatic ctrl_t pkt_ctrl(input packet_t pkt);
      return pkt[`PKT_CTRL_LSB +: 8];
   endfunction

   function automatic addr_t pkt_dst(input packet_t pkt);
      return pkt[`PKT_DST_LSB +: 32];
   endfunction

   function automatic data_t pkt_data(input packet_t pkt);
      return pkt[`PKT_DATA_LSB +: 32];
   endfunction

   function automatic addr_t pkt_src(input packet_t pkt);
      return pkt[`PKT_SRC_LSB +: 32];
   endfunction

   // Assemble a packet from its four fields
   function automatic packet_t pkt_make(input ctrl_t ctrl, input addr_t dst,
                                        input data_t data, input addr_t src);
      packet_t pkt;
      pkt                        = '0;
      pkt[`PKT_CTRL_LSB +: 8]    = ctrl;
      pkt[`PKT_DST_LSB +: 32]    = dst;
      pkt[`PKT_DATA_LSB +: 32]   = data;
      pkt[`PKT_SRC_LSB +: 32]    = src;
      return pkt;
   endfunction

endpackage

`default_nettype wire

//--- design/link_pkg.sv
`default_nettype none

package link_pkg;

   typedef logic [7:0] lane_t;              // One byte on the lane
   typedef logic [3:0] byte_cnt_t;          // Byte index within a packet

   // Transmitter sequencing
   typedef enum logic [0:0] {
      TX_IDLE,                              // Waiting for a held packet
      TX_SEND                               // Frame high, bytes going out
   } tx_state_t;

   // Receiver sequencing
   typedef enum logic [1:0] {
      RX_IDLE,                              // No frame seen
      RX_COLLECT,                           // Shifting bytes in
      RX_HOLD                               // Full packet parked, output busy
   } rx_state_t;

endpackage

`default_nettype wire

//--- design/link_tx.sv
`timescale 1ns/10ps
`default_nettype none
`include "link_consts.svh"

module link_tx
   import emesh_pkg::*;
   import link_pkg::*;
(
   input  logic      clkin,
   input  logic      reset,
   input  logic      txwr_access,
   input  logic      txrd_access,
   input  logic      txrr_access,
   input  packet_t   txwr_packet,
   input  packet_t   txrd_packet,
   input  packet_t   txrr_packet,
   output logic      txwr_wait,
   output logic      txrd_wait,
   output logic      txrr_wait,
   input  logic      link_wait,
   output lane_t     lane_data,
   output logic      lane_frame
);

   packet_t   hold_pkt;                     // Packet picked by the arbiter
   logic      hold_full;                    // Holding register occupied
   packet_t   pick_pkt;                     // Winner of this cycle
   logic      load_hold;                    // Winner enters holding register
   packet_t   shift_pkt;                    // Bytes still to send, LSB first
   byte_cnt_t byte_cnt;                     // Bytes already on the lane
   tx_state_t state;
   logic      start_send;                   // Holding register moves to shifter
   logic      last_byte;                    // Byte 12 on the lane

   // Fixed priority rr > wr > rd, responses first to keep the loop draining
   assign pick_pkt  = txrr_access ? txrr_packet :
                      txwr_access ? txwr_packet : txrd_packet;
   assign load_hold = ~hold_full & (txrr_access | txwr_access | txrd_access);

   // Lower priorities also wait while a higher one is offered
   assign txrr_wait = hold_full;
   assign txwr_wait = hold_full | txrr_access;
   assign txrd_wait = hold_full | txrr_access | txwr_access;

   assign start_send = (state == TX_IDLE) & hold_full & ~link_wait;
   assign last_byte  = (state == TX_SEND) &
                       (byte_cnt == byte_cnt_t'(`PKT_BYTES - 1));

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         hold_full <= 1'b0;
      end else if (load_hold) begin
         hold_full <= 1'b1;                 // Accepted on this edge
      end else if (start_send) begin
         hold_full <= 1'b0;                 // Free again while shifting
      end
   end

   always_ff @(posedge clkin) begin
      if (load_hold) begin
         hold_pkt <= pick_pkt;
      end
   end

   // Serializer, control byte leaves first
   always_ff @(posedge clkin) begin
      if (start_send) begin
         shift_pkt <= hold_pkt;
      end else if (state == TX_SEND) begin
         shift_pkt <= {8'h00, shift_pkt[`PKT_W-1:8]};
      end
   end

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         state    <= TX_IDLE;
         byte_cnt <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               if (start_send) begin
                  state    <= TX_SEND;
                  byte_cnt <= '0;
               end
            end
            TX_SEND: begin
               if (last_byte) begin
                  state <= TX_IDLE;         // One idle cycle between frames
               end else begin
                  byte_cnt <= byte_cnt + 4'd1;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   assign lane_frame = (state == TX_SEND);  // High for all 13 bytes
   assign lane_data  = shift_pkt[7:0];

endmodule

`default_nettype wire

//--- design/link_rx.sv
`timescale 1ns/10ps
`default_nettype none
`include "link_consts.svh"

module link_rx
   import emesh_pkg::*;
   import link_pkg::*;
(
   input  logic      clkin,
   input  logic      reset,
   input  lane_t     lane_data,
   input  logic      lane_frame,
   output logic      link_wait,
   output logic      rxwr_access,
   output logic      rxrd_access,
   output logic      rxrr_access,
   output packet_t   rxwr_packet,
   output packet_t   rxrd_packet,
   output packet_t   rxrr_packet,
   input  logic      rxwr_wait,
   input  logic      rxrd_wait,
   input  logic      rxrr_wait
);

   packet_t    asm_pkt;                     // Assembly shift register
   packet_t    full_pkt;                    // Assembly plus current lane byte
   packet_t    load_pkt;                    // Packet entering output register
   byte_cnt_t  byte_cnt;                    // Bytes collected so far
   rx_state_t  state;
   logic       done_byte;                   // 13th framed byte on the lane
   logic       move;                        // Output register loads this edge
   packet_t    out_pkt;
   logic       out_valid;
   logic [2:0] out_sel;                     // One-hot {rr, rd, wr}
   logic       sel_wait;                    // Wait of the chosen destination
   logic       out_free;

   // Response bit wins, then write bit, everything else is a read
   function automatic logic [2:0] route(input ctrl_t ctrl);
      if (ctrl[`CTRL_RESP_BIT]) begin
         return 3'b100;
      end else if (ctrl[`CTRL_WRITE_BIT]) begin
         return 3'b001;
      end
      return 3'b010;
   endfunction

   assign full_pkt  = {lane_data, asm_pkt[`PKT_W-1:8]};
   assign done_byte = (state == RX_COLLECT) & lane_frame &
                      (byte_cnt == byte_cnt_t'(`PKT_BYTES - 1));
   assign load_pkt  = (state == RX_HOLD) ? asm_pkt : full_pkt;

   assign sel_wait = |(out_sel & {rxrr_wait, rxrd_wait, rxwr_wait});
   assign out_free = ~out_valid | ~sel_wait;
   assign move     = (done_byte | (state == RX_HOLD)) & out_free;

   always_ff @(posedge clkin) begin
      if (lane_frame && state != RX_HOLD) begin
         asm_pkt <= full_pkt;               // New byte enters at the top
      end
   end

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         state    <= RX_IDLE;
         byte_cnt <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               if (lane_frame) begin
                  state    <= RX_COLLECT;
                  byte_cnt <= 4'd1;         // Control byte taken
               end
            end
            RX_COLLECT: begin
               if (!lane_frame) begin
                  state <= RX_IDLE;         // Short frame dropped
               end else if (done_byte) begin
                  state <= out_free ? RX_IDLE : RX_HOLD;
               end else begin
                  byte_cnt <= byte_cnt + 4'd1;
               end
            end
            RX_HOLD: begin
               if (out_free) begin
                  state <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // Output register, type decoded once on load
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         out_valid <= 1'b0;
         out_sel   <= '0;
      end else if (move) begin
         out_valid <= 1'b1;
         out_sel   <= route(pkt_ctrl(load_pkt));
      end else if (out_valid && !sel_wait) begin
         out_valid <= 1'b0;                 // Taken by destination
      end
   end

   always_ff @(posedge clkin) begin
      if (move) begin
         out_pkt <= load_pkt;
      end
   end

   assign link_wait   = out_valid;          // No new frame while occupied
   assign rxwr_access = out_valid & out_sel[0];
   assign rxrd_access = out_valid & out_sel[1];
   assign rxrr_access = out_valid & out_sel[2];
   assign rxwr_packet = out_pkt;
   assign rxrd_packet = out_pkt;
   assign rxrr_packet = out_pkt;

endmodule

`default_nettype wire

//--- design/emem_model.sv
`timescale 1ns/10ps
`default_nettype none
`include "link_consts.svh"

module emem_model
   import emesh_pkg::*;
(
   input  logic    clkin,
   input  logic    reset,
   input  logic    access_in,
   input  packet_t packet_in,
   output logic    wait_out,
   output logic    access_out,
   output packet_t packet_out,
   input  logic    wait_in
);

   data_t                mem [0:(1 << `EMEM_AW)-1];   // Word storage
   ctrl_t                in_ctrl;
   addr_t                in_dst;
   addr_t                in_src;
   data_t                in_data;
   logic [`EMEM_AW-1:0]  word_idx;          // Word address, wraps at 256
   logic                 do_write;
   logic                 do_read;
   ctrl_t                rsp_ctrl;
   logic                 resp_valid;        // Response held for the link
   packet_t              resp_pkt;

   assign in_ctrl  = pkt_ctrl(packet_in);
   assign in_dst   = pkt_dst(packet_in);
   assign in_src   = pkt_src(packet_in);
   assign in_data  = pkt_data(packet_in);
   assign word_idx = in_dst[`EMEM_AW+1:2];  // Byte address to word index

   // Writes never stall, reads only when no response is pending
   assign do_write = access_in & in_ctrl[`CTRL_WRITE_BIT];
   assign do_read  = access_in & ~in_ctrl[`CTRL_WRITE_BIT] & ~resp_valid;

   always_comb begin
      rsp_ctrl                  = in_ctrl;
      rsp_ctrl[`CTRL_RESP_BIT]  = 1'b1;     // Marks a read response
      rsp_ctrl[`CTRL_WRITE_BIT] = 1'b0;
   end

   always_ff @(posedge clkin) begin
      if (do_write) begin
         mem[word_idx] <= in_data;
      end
   end

   // Response swaps source and destination
   always_ff @(posedge clkin) begin
      if (do_read) begin
         resp_pkt <= pkt_make(rsp_ctrl, in_src, mem[word_idx], in_dst);
      end
   end

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         resp_valid <= 1'b0;
      end else if (do_read) begin
         resp_valid <= 1'b1;                // Ready the cycle after the read
      end else if (!wait_in) begin
         resp_valid <= 1'b0;
      end
   end

   assign access_out = resp_valid;
   assign packet_out = resp_pkt;
   assign wait_out   = resp_valid;          // Next read waits for drain

endmodule

`default_nettype wire

//--- design/elink_loop.sv
`timescale 1ns/10ps
`default_nettype none
`include "link_consts.svh"

module elink_loop
   import emesh_pkg::*;
   import link_pkg::*;
(
   input  logic    clkin,
   input  logic    reset,
   input  logic    ext_access,
   input  packet_t ext_packet,
   output logic    dut_rd_wait,
   output logic    dut_wr_wait,
   output logic    dut_access,
   output packet_t dut_packet,
   input  logic    ext_rd_wait
);

   ctrl_t   ext_ctrl;
   logic    txwr_access;                    // Host write path
   logic    txrd_access;                    // Host read path
   logic    txrr_access;                    // Memory response path
   packet_t txrr_packet;
   logic    txrr_wait;
   lane_t   lane_data;
   logic    lane_frame;
   logic    link_wait;
   logic    rxwr_access;
   logic    rxrd_access;
   packet_t rxwr_packet;
   packet_t rxrd_packet;
   logic    rxrd_wait;
   logic    emem_access;
   packet_t emem_packet;
   logic    emem_wait;

   // Host split on the write flag
   assign ext_ctrl    = pkt_ctrl(ext_packet);
   assign txwr_access = ext_access & ext_ctrl[`CTRL_WRITE_BIT];
   assign txrd_access = ext_access & ~ext_ctrl[`CTRL_WRITE_BIT];

   link_tx tx0 (
      .clkin       (clkin),
      .reset       (reset),
      .txwr_access (txwr_access),
      .txrd_access (txrd_access),
      .txrr_access (txrr_access),
      .txwr_packet (ext_packet),
      .txrd_packet (ext_packet),
      .txrr_packet (txrr_packet),
      .txwr_wait   (dut_wr_wait),           // Host push-back
      .txrd_wait   (dut_rd_wait),
      .txrr_wait   (txrr_wait),
      .link_wait   (link_wait),
      .lane_data   (lane_data),
      .lane_frame  (lane_frame)
   );

   link_rx rx0 (
      .clkin       (clkin),
      .reset       (reset),
      .lane_data   (lane_data),
      .lane_frame  (lane_frame),
      .link_wait   (link_wait),
      .rxwr_access (rxwr_access),
      .rxrd_access (rxrd_access),
      .rxrr_access (dut_access),            // Responses back to host
      .rxwr_packet (rxwr_packet),
      .rxrd_packet (rxrd_packet),
      .rxrr_packet (dut_packet),
      .rxwr_wait   (rxrd_access),           // Write stalls only behind an offered read
      .rxrd_wait   (rxrd_wait),
      .rxrr_wait   (ext_rd_wait)
   );

   // Single memory port, write wins
   assign emem_access = rxwr_access | rxrd_access;
   assign emem_packet = rxwr_access ? rxwr_packet : rxrd_packet;
   assign rxrd_wait   = emem_wait;

   emem_model emem0 (
      .clkin      (clkin),
      .reset      (reset),
      .access_in  (emem_access),
      .packet_in  (emem_packet),
      .wait_out   (emem_wait),
      .access_out (txrr_access),
      .packet_out (txrr_packet),
      .wait_in    (txrr_wait)               // Held until transmitter takes it
   );

endmodule

`default_nettype wire

//--- test/elink_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "link_consts.svh"

module elink_checker
   import emesh_pkg::*;
(
   input logic    clkin,
   input logic    reset,
   input logic    lane_frame,
   input logic    rxwr_access,
   input logic    rxrd_access,
   input logic    dut_access,
   input packet_t dut_packet,
   input logic    ext_rd_wait
);

   logic [4:0] frame_len;                   // Consecutive framed cycles so far

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         frame_len <= '0;
      end else if (lane_frame) begin
         frame_len <= frame_len + 5'd1;
      end else begin
         frame_len <= '0;
      end
   end

   frame_max: assert property (@(posedge clkin) disable iff (reset)
      lane_frame |-> frame_len < 5'(`PKT_BYTES))
      else $error("lane_frame longer than one packet");

   frame_end: assert property (@(posedge clkin) disable iff (reset)
      (!lane_frame && frame_len != 5'd0) |-> frame_len == 5'(`PKT_BYTES))
      else $error("lane_frame ended before a full packet");

   hold_stable: assert property (@(posedge clkin) disable iff (reset)
      (dut_access && ext_rd_wait) |=> (dut_access && $stable(dut_packet)))
      else $error("dut_packet changed under ext_rd_wait");

   // Async reset clears the receiver outputs at once
   reset_quiet: assert property (@(posedge clkin)
      reset |-> !(rxwr_access || rxrd_access || dut_access))
      else $error("Receiver access high during reset");

endmodule

bind elink_loop elink_checker chk0 (
   .clkin       (clkin),
   .reset       (reset),
   .lane_frame  (lane_frame),
   .rxwr_access (rxwr_access),
   .rxrd_access (rxrd_access),
   .dut_access  (dut_access),
   .dut_packet  (dut_packet),
   .ext_rd_wait (ext_rd_wait)
);

`default_nettype wire

//--- test/tb_elink_loop.sv
`timescale 1ns/10ps
`default_nettype none
`include "link_consts.svh"

module tb_elink_loop
   import emesh_pkg::*;
();

   localparam int NUM_ENTRIES    = 42;
   localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 60;    // Worst read round trip with margin

   typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_READ_HOLD} op_t;

   logic        clkin;
   logic        reset;
   logic        ext_access;
   packet_t     ext_packet;
   logic        dut_rd_wait;
   logic        dut_wr_wait;
   logic        dut_access;
   packet_t     dut_packet;
   logic        ext_rd_wait;

   op_t         tbl_op   [NUM_ENTRIES];     // Stimulus table
   addr_t       tbl_addr [NUM_ENTRIES];
   data_t       tbl_data [NUM_ENTRIES];
   int          tbl_hold [NUM_ENTRIES];     // Cycles ext_rd_wait stays high
   int          tbl_len;
   data_t       shadow [0:(1 << `EMEM_AW)-1];   // Expected memory contents
   packet_t     exp_queue [$];              // Responses in issue order
   logic [31:0] lcg_state;
   int          cycle_count;

   elink_loop dut0 (
      .clkin       (clkin),
      .reset       (reset),
      .ext_access  (ext_access),
      .ext_packet  (ext_packet),
      .dut_rd_wait (dut_rd_wait),
      .dut_wr_wait (dut_wr_wait),
      .dut_access  (dut_access),
      .dut_packet  (dut_packet),
      .ext_rd_wait (ext_rd_wait)
   );

   initial begin
      clkin = 1'b0;
      forever #4 clkin = ~clkin;            // 8 ns period
   end

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic fail_value(input string msg);
      stop_run($sformatf("[FAIL] %0t: %s", $time, msg));
   endtask

   task automatic compare_packet(input packet_t got, input packet_t exp, input string what);
      if (got !== exp) begin
         fail_value($sformatf("%s packet got %h expected %h", what, got, exp));
      end
   endtask

   task automatic compare_data(input data_t got, input data_t exp, input string what);
      if (got !== exp) begin
         fail_value($sformatf("%s got %h expected %h", what, got, exp));
      end
   endtask

   // Layout from bit 0 up: control, destination, data, source
   function automatic packet_t build_packet(input ctrl_t ctrl, input addr_t dst,
                                            input data_t data, input addr_t src);
      return {src, data, dst, ctrl};
   endfunction

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [`EMEM_AW-1:0] word_index(input addr_t addr);
      return addr[`EMEM_AW+1:2];            // Byte address to word, wraps at 256 words
   endfunction

   task automatic add_entry(input op_t op, input addr_t addr, input data_t data,
                            input int hold);
      tbl_op[tbl_len]   = op;
      tbl_addr[tbl_len] = addr;
      tbl_data[tbl_len] = data;
      tbl_hold[tbl_len] = hold;
      tbl_len           = tbl_len + 1;
   endtask

   task automatic build_table();
      add_entry(OP_WRITE, 32'h0000_0010, 32'ha5a5_0001, 0);    // Write then read back
      add_entry(OP_READ,  32'h0000_0010, 32'h0, 0);
      add_entry(OP_WRITE, 32'h0000_0020, 32'h1111_2222, 0);    // Overwrite
      add_entry(OP_WRITE, 32'h0000_0020, 32'h3333_4444, 0);
      add_entry(OP_READ,  32'h0000_0020, 32'h0, 0);
      add_entry(OP_WRITE, 32'h0000_0420, 32'h5555_6666, 0);    // 256 words above, same word
      add_entry(OP_READ,  32'h0000_0020, 32'h0, 0);
      add_entry(OP_READ,  32'h0000_0420, 32'h0, 0);
      for (int k = 0; k < 16; k++) begin
         lcg_state = lcg_next(lcg_state);
         add_entry(OP_WRITE, 32'h0000_0100 + 4 * k, lcg_state, 0);   // Back-to-back burst
      end
      for (int k = 0; k < 16; k++) begin
         add_entry(OP_READ, 32'h0000_0100 + 4 * k, 32'h0, 0);
      end
      add_entry(OP_READ_HOLD, 32'h0000_0010, 32'h0, 6);        // Host back-pressure
      add_entry(OP_READ_HOLD, 32'h0000_0104, 32'h0, 3);
   endtask

   // Entered and left 1 ns after a rising edge
   task automatic send_packet(input packet_t pkt, input logic is_write);
      logic accepted;
      ext_access = 1'b1;
      ext_packet = pkt;
      do begin
         @(negedge clkin);
         accepted = is_write ? !dut_wr_wait : !dut_rd_wait;
         @(posedge clkin);
         #1;
      end while (!accepted);
      ext_access = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_queue.size() != 0) begin
         @(posedge clkin);
         #1;
      end
   endtask

   task automatic hold_response(input packet_t exp, input int cycles);
      @(negedge clkin);
      while (!dut_access) begin
         @(negedge clkin);
      end
      for (int k = 0; k < cycles; k++) begin
         if (!dut_access) begin
            fail_value("dut_access dropped while ext_rd_wait was high");
         end
         compare_packet(dut_packet, exp, "Held response");
         @(negedge clkin);
      end
      @(posedge clkin);
      #1;
      ext_rd_wait = 1'b0;                   // Release, monitor takes it next
   endtask

   task automatic apply_entry(input int i);
      ctrl_t   wr_ctrl;
      ctrl_t   rsp_ctrl;
      addr_t   src;
      packet_t exp;
      wr_ctrl                   = '0;
      wr_ctrl[`CTRL_WRITE_BIT]  = 1'b1;
      rsp_ctrl                  = '0;
      rsp_ctrl[`CTRL_RESP_BIT]  = 1'b1;
      if (tbl_op[i] == OP_WRITE) begin
         shadow[word_index(tbl_addr[i])] = tbl_data[i];
         send_packet(build_packet(wr_ctrl, tbl_addr[i], tbl_data[i], 32'h0), 1'b1);
      end else begin
         src = 32'h8000_0000 + i;           // Unique return address per read
         exp = build_packet(rsp_ctrl, src, shadow[word_index(tbl_addr[i])], tbl_addr[i]);
         if (tbl_op[i] == OP_READ_HOLD) begin
            wait_drain();
            ext_rd_wait = 1'b1;
         end
         exp_queue.push_back(exp);
         send_packet(build_packet(8'h00, tbl_addr[i], 32'h0, src), 1'b0);
         if (tbl_op[i] == OP_READ_HOLD) begin
            hold_response(exp, tbl_hold[i]);
         end
      end
   endtask

   task automatic check_response();
      packet_t exp;
      if (exp_queue.size() == 0) begin
         stop_run("Response packet arrived with no read outstanding");
      end else begin
         exp = exp_queue.pop_front();
         compare_data(dut_packet[`PKT_DATA_LSB +: 32], exp[`PKT_DATA_LSB +: 32],
                      "Response data");
         compare_packet(dut_packet, exp, "Response");
      end
   endtask

   // Transfer happens on the edge after a negedge with access and no wait
   initial begin
      forever begin
         @(negedge clkin);
         if (!reset && dut_access && !ext_rd_wait) begin
            check_response();
         end
      end
   end

   initial begin
      cycle_count = 0;
      forever begin
         @(posedge clkin);
         cycle_count = cycle_count + 1;
         if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout, run did not finish in %0d cycles", TIMEOUT_CYCLES));
         end
      end
   end

   initial begin
      reset       = 1'b1;
      ext_access  = 1'b0;
      ext_packet  = '0;
      ext_rd_wait = 1'b0;
      lcg_state   = 32'h779f_63c0;
      tbl_len     = 0;
      build_table();
      repeat (3) @(posedge clkin);
      #1;
      reset = 1'b0;
      @(negedge clkin);
      if (dut_access || dut_rd_wait || dut_wr_wait) begin
         fail_value("Outputs not idle after reset");
      end
      @(posedge clkin);
      #1;
      for (int i = 0; i < tbl_len; i++) begin
         apply_entry(i);
      end
      wait_drain();
      repeat (2 * `PKT_BYTES) @(posedge clkin);   // Window for a stray extra response
      #1;
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/emesh_pkg.sv
design/link_pkg.sv
design/link_tx.sv
design/link_rx.sv
design/emem_model.sv
design/elink_loop.sv
test/elink_checker.sv
test/tb_elink_loop.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module tb_elink_loop
	./obj_dir/Vtb_elink_loop > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
